// File: src/mem_bus_pkg.sv
package mem_bus_pkg;

    // word geometry on both buses
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int LANES = DATA_W / 8;
    localparam int BYTE_OFF_W = $clog2(LANES);

    // one buffered line is a 64-byte block
    localparam int LINE_WORDS = 16;
    localparam int OFFSET_W = $clog2(LINE_WORDS);

    // burst bus field widths
    localparam int SIZE_W = 3;
    localparam int LEN_W = 4;

    // size code for 4-byte beats
    localparam logic [SIZE_W-1:0] MSIZE4 = 3'b010;

    // length code is beats minus one, so it doubles as the wrap mask
    localparam logic [LEN_W-1:0] MLEN16 = 4'b1111;

    // all lanes enabled
    localparam logic [LANES-1:0] FULL_STROBE = '1;

    // backing memory, 16 lines deep
    localparam int MEM_WORDS = 256;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

    // cycles from burst start to the first ready beat, at least 2
    localparam int FIRST_BEAT_LAT = 3;

    // word offset of a byte address inside its line
    function automatic logic [OFFSET_W-1:0] line_offset(
        input logic [ADDR_W-1:0] addr
    );
        return addr[BYTE_OFF_W +: OFFSET_W];
    endfunction

    // word index of a byte address in the backing memory
    function automatic logic [MEM_IDX_W-1:0] mem_index(
        input logic [ADDR_W-1:0] addr
    );
        return addr[BYTE_OFF_W +: MEM_IDX_W];
    endfunction

    // replace the enabled byte lanes of a word
    function automatic logic [DATA_W-1:0] merge_word(
        input logic [DATA_W-1:0] old_word,
        input logic [DATA_W-1:0] new_word,
        input logic [LANES-1:0]  lanes
    );
        logic [DATA_W-1:0] result;

        result = old_word;
        for (int i = 0; i < LANES; i++) begin
            if (lanes[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

endpackage

// File: src/line_store.sv
`timescale 1ns/1ps

module line_store (
    input  logic                             clk,
    input  logic                             resetn,

    // whole-word fill from the burst bus
    input  logic                             beat_we,
    input  logic [mem_bus_pkg::OFFSET_W-1:0] beat_offset,
    input  logic [mem_bus_pkg::DATA_W-1:0]   beat_data,

    // byte-lane merge from the data bus
    input  logic                             merge_en,
    input  logic [mem_bus_pkg::OFFSET_W-1:0] merge_offset,
    input  logic [mem_bus_pkg::LANES-1:0]    merge_lanes,
    input  logic [mem_bus_pkg::DATA_W-1:0]   merge_data,

    input  logic [mem_bus_pkg::OFFSET_W-1:0] rd_a_offset,
    output logic [mem_bus_pkg::DATA_W-1:0]   rd_a_data,
    input  logic [mem_bus_pkg::OFFSET_W-1:0] rd_b_offset,
    output logic [mem_bus_pkg::DATA_W-1:0]   rd_b_data
);
    import mem_bus_pkg::*;

    // each word seen as its byte lanes
    logic [LANES-1:0][7:0] words [LINE_WORDS];

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int i = 0; i < LINE_WORDS; i++) begin
                words[i] <= '0;
            end
        end else begin
            if (merge_en) begin
                words[merge_offset] <= merge_word(words[merge_offset], merge_data,
                                                  merge_lanes);
            end else if (beat_we) begin
                words[beat_offset] <= beat_data;
            end
        end
    end

    // read ports see the line as it stands this cycle
    assign rd_a_data = words[rd_a_offset];
    assign rd_b_data = words[rd_b_offset];

endmodule

// File: src/line_buffer.sv
`timescale 1ns/1ps

module line_buffer (
    input  logic                           clk,
    input  logic                           resetn,

    // data bus
    input  logic                           dreq_valid,
    input  logic [mem_bus_pkg::ADDR_W-1:0] dreq_addr,
    input  logic [mem_bus_pkg::LANES-1:0]  dreq_strobe,
    input  logic [mem_bus_pkg::DATA_W-1:0] dreq_data,
    output logic                           dresp_addr_ok,
    output logic                           dresp_data_ok,
    output logic [mem_bus_pkg::DATA_W-1:0] dresp_data,

    // burst bus
    output logic                           creq_valid,
    output logic                           creq_is_write,
    output logic [mem_bus_pkg::ADDR_W-1:0] creq_addr,
    output logic [mem_bus_pkg::SIZE_W-1:0] creq_size,
    output logic [mem_bus_pkg::LEN_W-1:0]  creq_len,
    output logic [mem_bus_pkg::LANES-1:0]  creq_strobe,
    output logic [mem_bus_pkg::DATA_W-1:0] creq_data,
    input  logic                           cresp_ready,
    input  logic                           cresp_last,
    input  logic [mem_bus_pkg::DATA_W-1:0] cresp_data
);
    import mem_bus_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,
        S_READY,
        S_FLUSH
    } state_t;

    state_t              state;
    logic [OFFSET_W-1:0] offset;

    // the request being served
    logic [ADDR_W-1:0]   req_addr;
    logic [LANES-1:0]    req_strobe;
    logic [DATA_W-1:0]   req_data;

    logic [OFFSET_W-1:0] start;
    logic                is_write;
    logic                beat_done;
    logic [DATA_W-1:0]   word_a;
    logic [DATA_W-1:0]   word_b;

    assign start     = line_offset(req_addr);
    assign is_write  = |req_strobe;
    assign beat_done = creq_valid && cresp_ready;

    assign dresp_addr_ok = (state == S_IDLE);
    assign dresp_data_ok = (state == S_READY);
    // old word, the merge lands at the end of the ready cycle
    assign dresp_data    = word_a;

    assign creq_valid    = (state == S_FETCH) || (state == S_FLUSH);
    assign creq_is_write = (state == S_FLUSH);
    assign creq_addr     = req_addr;
    assign creq_size     = MSIZE4;
    assign creq_len      = MLEN16;
    assign creq_strobe   = FULL_STROBE;
    assign creq_data     = word_b;

    line_store i_line_store (
        .clk          (clk),
        .resetn       (resetn),
        .beat_we      (beat_done && (state == S_FETCH)),
        .beat_offset  (offset),
        .beat_data    (cresp_data),
        .merge_en     ((state == S_READY) && is_write),
        .merge_offset (start),
        .merge_lanes  (req_strobe),
        .merge_data   (req_data),
        .rd_a_offset  (start),
        .rd_a_data    (word_a),
        .rd_b_offset  (offset),
        .rd_b_data    (word_b)
    );

    always_ff @(posedge clk) begin
        if (dresp_addr_ok && dreq_valid) begin
            req_addr   <= dreq_addr;
            req_strobe <= dreq_strobe;
            req_data   <= dreq_data;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state  <= S_IDLE;
            offset <= '0;
        end else begin
            unique case (state)
                S_IDLE: begin
                    if (dreq_valid) begin
                        state  <= S_FETCH;
                        offset <= line_offset(dreq_addr);
                    end
                end
                // critical word first, offset wraps inside the line
                S_FETCH: begin
                    if (beat_done) begin
                        offset <= offset + 1'b1;
                        if (cresp_last) begin
                            state <= S_READY;
                        end
                    end
                end
                S_READY: begin
                    offset <= start;
                    state  <= is_write ? S_FLUSH : S_IDLE;
                end
                S_FLUSH: begin
                    if (beat_done) begin
                        offset <= offset + 1'b1;
                        if (cresp_last) begin
                            state <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// File: src/burst_ram.sv
`timescale 1ns/1ps

module burst_ram (
    input  logic                           clk,
    input  logic                           resetn,

    input  logic                           creq_valid,
    input  logic                           creq_is_write,
    input  logic [mem_bus_pkg::ADDR_W-1:0] creq_addr,
    input  logic [mem_bus_pkg::SIZE_W-1:0] creq_size,
    input  logic [mem_bus_pkg::LEN_W-1:0]  creq_len,
    input  logic [mem_bus_pkg::LANES-1:0]  creq_strobe,
    input  logic [mem_bus_pkg::DATA_W-1:0] creq_data,
    output logic                           cresp_ready,
    output logic                           cresp_last,
    output logic [mem_bus_pkg::DATA_W-1:0] cresp_data
);
    import mem_bus_pkg::*;

    localparam int WAIT_W = $clog2(FIRST_BEAT_LAT + 1);

    typedef enum logic [1:0] {
        B_IDLE,
        B_WAIT,
        B_BEAT
    } state_t;

    state_t            state;
    logic [WAIT_W-1:0] wait_cnt;
    logic [LEN_W-1:0]  beat;

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [DATA_W-1:0] rd_data;

    logic [MEM_IDX_W-1:0] base_idx;
    logic [LEN_W-1:0]     fetch_beat;
    logic [MEM_IDX_W-1:0] cur_idx;
    logic [MEM_IDX_W-1:0] fetch_idx;
    logic [LANES-1:0]     wr_lanes;
    logic                 beat_done;

    // index of a beat, wrapping inside the block that creq_len covers
    function automatic logic [MEM_IDX_W-1:0] wrap_idx(
        input logic [MEM_IDX_W-1:0] base,
        input logic [LEN_W-1:0]     len,
        input logic [LEN_W-1:0]     n
    );
        logic [LEN_W-1:0] low;

        low = (base[LEN_W-1:0] & ~len) | ((base[LEN_W-1:0] + n) & len);
        return {base[MEM_IDX_W-1:LEN_W], low};
    endfunction

    assign base_idx  = mem_index(creq_addr);
    assign cur_idx   = wrap_idx(base_idx, creq_len, beat);
    // beat whose data must sit in rd_data next cycle
    assign fetch_beat = (state == B_BEAT) ? beat + 1'b1 : '0;
    assign fetch_idx = wrap_idx(base_idx, creq_len, fetch_beat);

    // only word beats write
    assign wr_lanes  = (creq_size == MSIZE4) ? creq_strobe : '0;
    assign beat_done = creq_valid && cresp_ready;

    assign cresp_ready = (state == B_BEAT);
    assign cresp_last  = cresp_ready && (beat == creq_len);
    assign cresp_data  = rd_data;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state    <= B_IDLE;
            wait_cnt <= '0;
            beat     <= '0;
        end else begin
            unique case (state)
                B_IDLE: begin
                    if (creq_valid) begin
                        state    <= B_WAIT;
                        wait_cnt <= WAIT_W'(FIRST_BEAT_LAT - 1);
                    end
                end
                B_WAIT: begin
                    if (wait_cnt == WAIT_W'(1)) begin
                        state <= B_BEAT;
                        beat  <= '0;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                B_BEAT: begin
                    if (beat_done) begin
                        if (cresp_last) begin
                            state <= B_IDLE;
                        end else begin
                            beat <= beat + 1'b1;
                        end
                    end
                end
                default: state <= B_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (beat_done && creq_is_write) begin
            mem[cur_idx] <= merge_word(mem[cur_idx], creq_data, wr_lanes);
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[fetch_idx];
    end

endmodule

// File: src/line_buffer_sys.sv
`timescale 1ns/1ps

module line_buffer_sys (
    input  logic                           clk,
    input  logic                           resetn,

    input  logic                           dreq_valid,
    input  logic [mem_bus_pkg::ADDR_W-1:0] dreq_addr,
    input  logic [mem_bus_pkg::LANES-1:0]  dreq_strobe,
    input  logic [mem_bus_pkg::DATA_W-1:0] dreq_data,
    output logic                           dresp_addr_ok,
    output logic                           dresp_data_ok,
    output logic [mem_bus_pkg::DATA_W-1:0] dresp_data
);

    // burst bus between buffer and memory
    logic                           creq_valid;
    logic                           creq_is_write;
    logic [mem_bus_pkg::ADDR_W-1:0] creq_addr;
    logic [mem_bus_pkg::SIZE_W-1:0] creq_size;
    logic [mem_bus_pkg::LEN_W-1:0]  creq_len;
    logic [mem_bus_pkg::LANES-1:0]  creq_strobe;
    logic [mem_bus_pkg::DATA_W-1:0] creq_data;
    logic                           cresp_ready;
    logic                           cresp_last;
    logic [mem_bus_pkg::DATA_W-1:0] cresp_data;

    line_buffer i_line_buffer (
        .clk           (clk),
        .resetn        (resetn),
        .dreq_valid    (dreq_valid),
        .dreq_addr     (dreq_addr),
        .dreq_strobe   (dreq_strobe),
        .dreq_data     (dreq_data),
        .dresp_addr_ok (dresp_addr_ok),
        .dresp_data_ok (dresp_data_ok),
        .dresp_data    (dresp_data),
        .creq_valid    (creq_valid),
        .creq_is_write (creq_is_write),
        .creq_addr     (creq_addr),
        .creq_size     (creq_size),
        .creq_len      (creq_len),
        .creq_strobe   (creq_strobe),
        .creq_data     (creq_data),
        .cresp_ready   (cresp_ready),
        .cresp_last    (cresp_last),
        .cresp_data    (cresp_data)
    );

    burst_ram i_burst_ram (
        .clk           (clk),
        .resetn        (resetn),
        .creq_valid    (creq_valid),
        .creq_is_write (creq_is_write),
        .creq_addr     (creq_addr),
        .creq_size     (creq_size),
        .creq_len      (creq_len),
        .creq_strobe   (creq_strobe),
        .creq_data     (creq_data),
        .cresp_ready   (cresp_ready),
        .cresp_last    (cresp_last),
        .cresp_data    (cresp_data)
    );

endmodule

// File: bench/line_buffer_sys_properties.sv
`timescale 1ns/1ps

module line_buffer_sys_properties (
    input logic                           clk,
    input logic                           resetn,
    input logic                           dresp_addr_ok,
    input logic                           dresp_data_ok,
    input logic                           creq_valid,
    input logic                           creq_is_write,
    input logic [mem_bus_pkg::ADDR_W-1:0] creq_addr,
    input logic [mem_bus_pkg::SIZE_W-1:0] creq_size,
    input logic [mem_bus_pkg::LEN_W-1:0]  creq_len,
    input logic [mem_bus_pkg::LANES-1:0]  creq_strobe,
    input logic [mem_bus_pkg::DATA_W-1:0] creq_data,
    input logic                           cresp_ready,
    input logic                           cresp_last
);

    no_ok_overlap: assert property (@(posedge clk) disable iff (resetn)
        !(dresp_addr_ok && dresp_data_ok))
        else $error("addr_ok and data_ok high together");

    data_ok_one_cycle: assert property (@(posedge clk) disable iff (resetn)
        dresp_data_ok |=> !dresp_data_ok)
        else $error("data_ok held longer than one cycle");

    // request held while the memory is not ready
    creq_stable: assert property (@(posedge clk) disable iff (resetn)
        creq_valid && !cresp_ready |=> creq_valid && $stable({creq_is_write, creq_addr,
            creq_size, creq_len, creq_strobe, creq_data}))
        else $error("burst request changed while waiting for ready");

    // the last flag marks a beat that really transfers
    last_with_ready: assert property (@(posedge clk) disable iff (resetn)
        cresp_last |-> cresp_ready && creq_valid)
        else $error("cresp_last outside a transferred beat");

endmodule

// File: bench/line_buffer_sys_tb.sv
`timescale 1ns/1ps

module line_buffer_sys_tb;
    import mem_bus_pkg::*;

    localparam int TIMEOUT = 4 * (LINE_WORDS + FIRST_BEAT_LAT);
    localparam int NUM_DIRECTED = 20;
    localparam int NUM_RANDOM = 12;

    typedef struct packed {
        logic [LANES-1:0]  strobe;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } entry_t;

    // strobe, byte address, write data; a zero strobe is a read
    localparam entry_t DIRECTED [NUM_DIRECTED] = '{
        '{4'h0, 32'h0000_0000, 32'h0000_0000},
        '{4'hf, 32'h0000_0004, 32'hdead_beef},
        '{4'h0, 32'h0000_0004, 32'h0000_0000},
        '{4'h5, 32'h0000_0004, 32'h1122_3344},
        '{4'h0, 32'h0000_0004, 32'h0000_0000},
        // last word of line 0, then a mid-line word
        '{4'hf, 32'h0000_003c, 32'ha5a5_0f0f},
        '{4'hf, 32'h0000_0020, 32'h1234_5678},
        '{4'h0, 32'h0000_0038, 32'h0000_0000},
        '{4'h0, 32'h0000_0000, 32'h0000_0000},
        '{4'h0, 32'h0000_0004, 32'h0000_0000},
        '{4'h0, 32'h0000_003c, 32'h0000_0000},
        '{4'h0, 32'h0000_0020, 32'h0000_0000},
        '{4'h0, 32'h0000_0024, 32'h0000_0000},
        // other lines
        '{4'hf, 32'h0000_0148, 32'hcafe_0001},
        '{4'hc, 32'h0000_030c, 32'hbeef_0000},
        '{4'h0, 32'h0000_0148, 32'h0000_0000},
        '{4'h0, 32'h0000_030c, 32'h0000_0000},
        '{4'h0, 32'h0000_003c, 32'h0000_0000},
        '{4'h3, 32'h0000_03fc, 32'h7777_9999},
        '{4'h0, 32'h0000_03fc, 32'h0000_0000}
    };

    logic              clk;
    logic              resetn;
    logic              dreq_valid;
    logic [ADDR_W-1:0] dreq_addr;
    logic [LANES-1:0]  dreq_strobe;
    logic [DATA_W-1:0] dreq_data;
    logic              dresp_addr_ok;
    logic              dresp_data_ok;
    logic [DATA_W-1:0] dresp_data;

    entry_t            stim [$];
    logic [DATA_W-1:0] shadow [MEM_WORDS];
    int                seed;
    int                errors;

    line_buffer_sys i_line_buffer_sys (
        .clk           (clk),
        .resetn        (resetn),
        .dreq_valid    (dreq_valid),
        .dreq_addr     (dreq_addr),
        .dreq_strobe   (dreq_strobe),
        .dreq_data     (dreq_data),
        .dresp_addr_ok (dresp_addr_ok),
        .dresp_data_ok (dresp_data_ok),
        .dresp_data    (dresp_data)
    );

    bind line_buffer line_buffer_sys_properties i_line_buffer_sys_properties (
        .clk           (clk),
        .resetn        (resetn),
        .dresp_addr_ok (dresp_addr_ok),
        .dresp_data_ok (dresp_data_ok),
        .creq_valid    (creq_valid),
        .creq_is_write (creq_is_write),
        .creq_addr     (creq_addr),
        .creq_size     (creq_size),
        .creq_len      (creq_len),
        .creq_strobe   (creq_strobe),
        .creq_data     (creq_data),
        .cresp_ready   (cresp_ready),
        .cresp_last    (cresp_last)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_error(input string line);
        errors++;
        $display("%s", line);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input logic [DATA_W-1:0] actual,
                               input logic [DATA_W-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_on_error($sformatf("FAIL at %0t ns: %s, got %h, expected %h",
                                    $time, what, actual, expected));
        end
    endtask

    // expected word after a lane-enabled write
    function automatic logic [DATA_W-1:0] lane_merge(input logic [DATA_W-1:0] old_word,
                                                     input logic [DATA_W-1:0] new_word,
                                                     input logic [LANES-1:0]  lanes);
        logic [DATA_W-1:0] mask;

        for (int i = 0; i < LANES; i++) begin
            mask[8*i +: 8] = {8{lanes[i]}};
        end
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    // both waits run on falling edges
    task automatic wait_addr_ok();
        int cycles;

        cycles = 0;
        while (!dresp_addr_ok) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_on_error($sformatf("timeout at %0t ns: dresp_addr_ok never came back",
                                        $time));
            end
        end
    endtask

    task automatic wait_data_ok();
        int cycles;

        cycles = 0;
        while (!dresp_data_ok) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_on_error($sformatf("timeout at %0t ns: dresp_data_ok never arrived",
                                        $time));
            end
        end
    endtask

    task automatic run_entry(input entry_t e, input logic [DATA_W-1:0] expected, input int n);
        wait_addr_ok();
        dreq_valid  = 1'b1;
        dreq_addr   = e.addr;
        dreq_strobe = e.strobe;
        dreq_data   = e.data;
        @(posedge clk);
        @(negedge clk);
        dreq_valid  = 1'b0;
        dreq_strobe = '0;
        check_value(dresp_addr_ok, 1'b0, $sformatf("entry %0d addr_ok after accept", n));
        @(negedge clk);
        wait_data_ok();
        check_value(dresp_data, expected,
                    $sformatf("entry %0d data at addr %h", n, e.addr));
    endtask

    initial begin
        entry_t            e;
        logic [DATA_W-1:0] expected;
        logic [31:0]       r;
        int                idx;

        resetn      = 1'b1;
        dreq_valid  = 1'b0;
        dreq_addr   = '0;
        dreq_strobe = '0;
        dreq_data   = '0;
        errors      = 0;
        seed        = 32'h4ccb9139;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = '0;
        end

        foreach (DIRECTED[i]) begin
            stim.push_back(DIRECTED[i]);
        end
        repeat (NUM_RANDOM) begin
            r = $random(seed);
            e.strobe = r[LANES-1:0];
            r = $random(seed);
            e.addr = ADDR_W'({r[MEM_IDX_W-1:0], 2'b00});
            e.data = $random(seed);
            stim.push_back(e);
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        resetn = 1'b0;
        check_value(dresp_addr_ok, 1'b1, "addr_ok after reset");
        check_value(dresp_data_ok, 1'b0, "data_ok after reset");

        foreach (stim[i]) begin
            e = stim[i];
            idx = (e.addr >> 2) % MEM_WORDS;
            // a write answers with the word before its merge
            expected = shadow[idx];
            if (e.strobe != '0) begin
                shadow[idx] = lane_merge(shadow[idx], e.data, e.strobe);
            end
            run_entry(e, expected, i);
        end
        wait_addr_ok();

        if (errors == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "errors found");
        end
    end

endmodule

// File: line_buffer_sys.f
src/mem_bus_pkg.sv
src/line_store.sv
src/line_buffer.sv
src/burst_ram.sv
src/line_buffer_sys.sv
bench/line_buffer_sys_properties.sv
bench/line_buffer_sys_tb.sv
